// ==== design/serial_link_macros.svh ====
////////////////////
// Serial link constants
// Lane count, credit count, word and frame widths
// Clock divider setting width
////////////////////

`ifndef SERIAL_LINK_MACROS_SVH
`define SERIAL_LINK_MACROS_SVH

// Data lanes on the link
`define SL_NUM_LANES 8

// Receive FIFO depth, also the initial credit count
`define SL_NUM_CREDITS 4

// Payload word
`define SL_WORD_BITS 32

// Frame padded up to a whole number of flits
`define SL_FRAME_BITS 40
`define SL_NUM_FLITS 5

// Runtime clock divider setting
`define SL_CLK_DIV_BITS 8

`endif

// ==== design/serial_link_pkg.sv ====
////////////////////
// Serial link package
// Word, flit, credit and divider types
// Frame layout and transmit FSM states
////////////////////

`include "serial_link_macros.svh"

package serial_link_pkg;

  typedef logic [`SL_WORD_BITS-1:0] word_t;
  typedef logic [`SL_NUM_LANES-1:0] flit_t;

  // Wide enough for 0 up to the full credit count
  typedef logic [$clog2(`SL_NUM_CREDITS + 1)-1:0] credit_t;

  typedef logic [`SL_CLK_DIV_BITS-1:0] clk_div_t;

  // Unused upper bits of the frame
  localparam int unsigned PadBits = `SL_FRAME_BITS - `SL_WORD_BITS - 1 - $bits(credit_t);

  // Frame on the wire, word in the low bits so it leaves first
  typedef struct packed {
    logic [PadBits-1:0] pad;
    credit_t            credit;
    logic               word_valid;
    word_t              word;
  } frame_t;

  // Physical transmit FSM
  typedef enum logic [1:0] {
    IDLE,
    HIGH,
    LOW
  } tx_state_e;

endpackage

// ==== design/serial_link_flow_ctrl.sv ====
////////////////////
// Serial link flow control
// Credit counter and pending credit returns
// Outgoing frame register, receive FIFO
////////////////////

`include "serial_link_macros.svh"

module serial_link_flow_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  serial_link_pkg::word_t  tx_word_i,
  input  logic                    tx_valid_i,
  output logic                    tx_ready_o,
  output serial_link_pkg::frame_t frame_tx_o,
  output logic                    frame_tx_valid_o,
  input  logic                    frame_tx_ready_i,
  input  serial_link_pkg::frame_t frame_rx_i,
  input  logic                    frame_rx_valid_i,
  output serial_link_pkg::word_t  rx_word_o,
  output logic                    rx_valid_o,
  input  logic                    rx_ready_i
);
  import serial_link_pkg::*;

  localparam int unsigned PtrBits = $clog2(`SL_NUM_CREDITS);

  credit_t            credit_cnt_q;
  credit_t            pending_q;
  credit_t            rx_credit;
  frame_t             frame_q;
  logic               frame_valid_q;
  logic               load;
  logic               send_word;
  logic               send_frame;

  word_t              fifo_mem [`SL_NUM_CREDITS];
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  credit_t            fifo_cnt_q;
  logic               push;
  logic               pop;

  function automatic logic [PtrBits-1:0] next_ptr(input logic [PtrBits-1:0] ptr);
    if (ptr == PtrBits'(`SL_NUM_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Transmit side
  ////////////////////

  // Frame register can take a new frame when empty or being drained
  assign load       = !frame_valid_q || frame_tx_ready_i;
  assign tx_ready_o = load && (credit_cnt_q != '0);
  assign send_word  = tx_valid_i && tx_ready_o;
  // Credit-only frame when nothing to send but returns are pending
  assign send_frame = load && (send_word || (pending_q != '0));

  assign frame_tx_o       = frame_q;
  assign frame_tx_valid_o = frame_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      frame_valid_q <= 1'b0;
    end else if (load) begin
      frame_valid_q <= send_frame;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_frame) begin
      frame_q.word       <= tx_word_i;
      frame_q.word_valid <= send_word;
      frame_q.credit     <= pending_q;
      frame_q.pad        <= '0;
    end
  end

  assign rx_credit = frame_rx_valid_i ? frame_rx_i.credit : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_cnt_q <= credit_t'(`SL_NUM_CREDITS);
      pending_q    <= '0;
    end else begin
      credit_cnt_q <= credit_cnt_q - credit_t'(send_word) + rx_credit;
      // All pending returns leave with the frame just built
      pending_q    <= (send_frame ? '0 : pending_q) + credit_t'(pop);
    end
  end

  ////////////////////
  // Receive FIFO
  ////////////////////

  // Never overflows, the sender holds at most one credit per slot
  assign push = frame_rx_valid_i && frame_rx_i.word_valid;
  assign pop  = rx_valid_o && rx_ready_i;

  assign rx_valid_o = fifo_cnt_q != '0;
  assign rx_word_o  = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      fifo_cnt_q <= fifo_cnt_q + credit_t'(push) - credit_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= frame_rx_i.word;
    end
  end

endmodule

// ==== design/serial_link_data_link.sv ====
////////////////////
// Serial link data link layer
// Frame to flit split, least significant first
// Flit to frame merge on receive
////////////////////

`include "serial_link_macros.svh"

module serial_link_data_link (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  serial_link_pkg::frame_t frame_tx_i,
  input  logic                    frame_tx_valid_i,
  output logic                    frame_tx_ready_o,
  output serial_link_pkg::flit_t  flit_tx_o,
  output logic                    flit_tx_valid_o,
  input  logic                    flit_tx_ready_i,
  input  serial_link_pkg::flit_t  flit_rx_i,
  input  logic                    flit_rx_valid_i,
  output serial_link_pkg::frame_t frame_rx_o,
  output logic                    frame_rx_valid_o
);
  import serial_link_pkg::*;

  localparam int unsigned IdxBits = $clog2(`SL_NUM_FLITS);
  localparam logic [IdxBits-1:0] LastIdx = IdxBits'(`SL_NUM_FLITS - 1);

  flit_t [`SL_NUM_FLITS-1:0] tx_flits_q;
  flit_t [`SL_NUM_FLITS-1:0] rx_flits_q;
  logic [IdxBits-1:0]        tx_idx_q;
  logic [IdxBits-1:0]        rx_idx_q;
  logic                      tx_busy_q;
  logic                      rx_done_q;
  logic                      frame_accept;
  logic                      flit_sent;

  ////////////////////
  // Send
  ////////////////////

  // One frame in flight, next one accepted after the last flit goes
  assign frame_tx_ready_o = !tx_busy_q;
  assign frame_accept     = frame_tx_valid_i && frame_tx_ready_o;
  assign flit_sent        = flit_tx_valid_o && flit_tx_ready_i;

  assign flit_tx_o       = tx_flits_q[tx_idx_q];
  assign flit_tx_valid_o = tx_busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_busy_q <= 1'b0;
      tx_idx_q  <= '0;
    end else if (frame_accept) begin
      tx_busy_q <= 1'b1;
      tx_idx_q  <= '0;
    end else if (flit_sent) begin
      tx_busy_q <= tx_idx_q != LastIdx;
      tx_idx_q  <= (tx_idx_q == LastIdx) ? '0 : tx_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_accept) begin
      tx_flits_q <= frame_tx_i;
    end
  end

  ////////////////////
  // Receive
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_idx_q  <= '0;
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= flit_rx_valid_i && (rx_idx_q == LastIdx);
      if (flit_rx_valid_i) begin
        rx_idx_q <= (rx_idx_q == LastIdx) ? '0 : rx_idx_q + 1'b1;
      end
    end
  end

  // New flits enter at the top, first flit ends up at index 0
  always_ff @(posedge clk_i) begin
    if (flit_rx_valid_i) begin
      rx_flits_q <= {flit_rx_i, rx_flits_q[`SL_NUM_FLITS-1:1]};
    end
  end

  assign frame_rx_o       = frame_t'(rx_flits_q);
  assign frame_rx_valid_o = rx_done_q;

endmodule

// ==== design/serial_link_phy_tx.sv ====
////////////////////
// Serial link transmit PHY
// Clock divider and forwarded clock
// Lane driving, one flit per period
////////////////////

module serial_link_phy_tx (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  serial_link_pkg::clk_div_t clk_div_i,
  input  serial_link_pkg::flit_t    flit_i,
  input  logic                      flit_valid_i,
  output logic                      flit_ready_o,
  output serial_link_pkg::flit_t    ddr_o,
  output logic                      ddr_rcv_clk_o
);
  import serial_link_pkg::*;

  tx_state_e state_q;
  clk_div_t  cnt_q;
  clk_div_t  half_last;
  flit_t     ddr_q;
  logic      clk_q;
  logic      half_done;
  logic      take_flit;

  // Each half of the forwarded clock lasts clk_div_i / 2 cycles
  assign half_last = (clk_div_i >> 1) - clk_div_t'(1);
  assign half_done = cnt_q == half_last;

  assign flit_ready_o = (state_q == IDLE) || ((state_q == LOW) && half_done);
  assign take_flit    = flit_valid_i && flit_ready_o;

  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = clk_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      ddr_q   <= '0;
      clk_q   <= 1'b0;
    end else begin
      unique case (state_q)
        HIGH: begin
          if (half_done) begin
            state_q <= LOW;
            clk_q   <= 1'b0;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        LOW: begin
          if (half_done) begin
            state_q <= IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: cnt_q <= '0;
      endcase
      // Lanes only change together with the rising forwarded clock
      if (take_flit) begin
        state_q <= HIGH;
        cnt_q   <= '0;
        clk_q   <= 1'b1;
        ddr_q   <= flit_i;
      end
    end
  end

endmodule

// ==== design/serial_link_phy_rx.sv ====
////////////////////
// Serial link receive PHY
// Received clock edge detect, flit capture
////////////////////

module serial_link_phy_rx (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  serial_link_pkg::flit_t ddr_i,
  input  logic                   ddr_rcv_clk_i,
  output serial_link_pkg::flit_t flit_o,
  output logic                   flit_valid_o
);
  import serial_link_pkg::*;

  flit_t lanes_sync_q;
  flit_t flit_q;
  logic  clk_sync_q;
  logic  clk_prev_q;
  logic  valid_q;
  logic  rise;

  // Rising edge of the sampled forwarded clock
  assign rise = clk_sync_q && !clk_prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clk_sync_q <= 1'b0;
      clk_prev_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      clk_sync_q <= ddr_rcv_clk_i;
      clk_prev_q <= clk_sync_q;
      valid_q    <= rise;
    end
  end

  // Lanes share the sync stage so they line up with the clock sample
  always_ff @(posedge clk_i) begin
    lanes_sync_q <= ddr_i;
    if (rise) begin
      flit_q <= lanes_sync_q;
    end
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = valid_q;

endmodule

// ==== design/serial_link.sv ====
////////////////////
// Serial link top level
// Flow control, data link and PHY instances
////////////////////

module serial_link (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  serial_link_pkg::clk_div_t clk_div_i,
  input  serial_link_pkg::word_t    tx_word_i,
  input  logic                      tx_valid_i,
  output logic                      tx_ready_o,
  output serial_link_pkg::word_t    rx_word_o,
  output logic                      rx_valid_o,
  input  logic                      rx_ready_i,
  output serial_link_pkg::flit_t    ddr_o,
  output logic                      ddr_rcv_clk_o,
  input  serial_link_pkg::flit_t    ddr_i,
  input  logic                      ddr_rcv_clk_i
);
  import serial_link_pkg::*;

  frame_t fc2dl_frame;
  logic   fc2dl_frame_valid;
  logic   dl2fc_frame_ready;
  frame_t dl2fc_frame;
  logic   dl2fc_frame_valid;
  flit_t  dl2phy_flit;
  logic   dl2phy_flit_valid;
  logic   phy2dl_flit_ready;
  flit_t  phy2dl_flit;
  logic   phy2dl_flit_valid;

  ////////////////////
  // Network layer
  ////////////////////

  serial_link_flow_ctrl i_flow_ctrl (
    .clk_i            ( clk_i             ),
    .rst_i            ( rst_i             ),
    .tx_word_i        ( tx_word_i         ),
    .tx_valid_i       ( tx_valid_i        ),
    .tx_ready_o       ( tx_ready_o        ),
    .frame_tx_o       ( fc2dl_frame       ),
    .frame_tx_valid_o ( fc2dl_frame_valid ),
    .frame_tx_ready_i ( dl2fc_frame_ready ),
    .frame_rx_i       ( dl2fc_frame       ),
    .frame_rx_valid_i ( dl2fc_frame_valid ),
    .rx_word_o        ( rx_word_o         ),
    .rx_valid_o       ( rx_valid_o        ),
    .rx_ready_i       ( rx_ready_i        )
  );

  ////////////////////
  // Data link layer
  ////////////////////

  serial_link_data_link i_data_link (
    .clk_i            ( clk_i             ),
    .rst_i            ( rst_i             ),
    .frame_tx_i       ( fc2dl_frame       ),
    .frame_tx_valid_i ( fc2dl_frame_valid ),
    .frame_tx_ready_o ( dl2fc_frame_ready ),
    .flit_tx_o        ( dl2phy_flit       ),
    .flit_tx_valid_o  ( dl2phy_flit_valid ),
    .flit_tx_ready_i  ( phy2dl_flit_ready ),
    .flit_rx_i        ( phy2dl_flit       ),
    .flit_rx_valid_i  ( phy2dl_flit_valid ),
    .frame_rx_o       ( dl2fc_frame       ),
    .frame_rx_valid_o ( dl2fc_frame_valid )
  );

  ////////////////////
  // Physical layer
  ////////////////////

  serial_link_phy_tx i_phy_tx (
    .clk_i         ( clk_i             ),
    .rst_i         ( rst_i             ),
    .clk_div_i     ( clk_div_i         ),
    .flit_i        ( dl2phy_flit       ),
    .flit_valid_i  ( dl2phy_flit_valid ),
    .flit_ready_o  ( phy2dl_flit_ready ),
    .ddr_o         ( ddr_o             ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o     )
  );

  serial_link_phy_rx i_phy_rx (
    .clk_i         ( clk_i             ),
    .rst_i         ( rst_i             ),
    .ddr_i         ( ddr_i             ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i     ),
    .flit_o        ( phy2dl_flit       ),
    .flit_valid_o  ( phy2dl_flit_valid )
  );

endmodule

// ==== sim/serial_link_checker.sv ====
////////////////////
// Serial link checker
// Model queue of expected words, rx stream monitor
// Value compare, per-test results
////////////////////

module serial_link_checker (
  input logic                   clk_i,
  input logic                   tx_ready_i,
  input serial_link_pkg::word_t rx_word_i,
  input logic                   rx_valid_i,
  input logic                   rx_ready_i,
  input serial_link_pkg::flit_t ddr_i,
  input logic                   ddr_rcv_clk_i
);
  import serial_link_pkg::*;

  word_t       model_q[$];
  int unsigned err_cnt = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  task automatic push_word(input word_t w);
    model_q.push_back(w);
  endtask

  function automatic int unsigned pending_count();
    return model_q.size();
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    err_cnt++;
  endtask

  // Idle link and empty FIFO right after reset
  task automatic check_reset_state();
    compare("tx_ready_o", 32'd1, 32'(tx_ready_i));
    compare("rx_valid_o", 32'd0, 32'(rx_valid_i));
    compare("ddr_rcv_clk_o", 32'd0, 32'(ddr_rcv_clk_i));
    compare("ddr_o", 32'd0, 32'(ddr_i));
  endtask

  task automatic end_test(input string label);
    if (err_cnt == 0) begin
      $display("test %s ... ok", label);
      tests_passed++;
    end else begin
      $display("test %s ... FAILED with %0d errors", label, err_cnt);
      tests_failed++;
    end
    err_cnt = 0;
  endtask

  // Every rx transfer must match the oldest word accepted on tx
  always @(posedge clk_i) begin
    if (rx_valid_i && rx_ready_i) begin
      if (model_q.size() == 0) begin
        report_error("word appeared on rx_word_o with no word outstanding");
      end else begin
        compare("rx_word_o", model_q.pop_front(), rx_word_i);
      end
    end
  end

endmodule

// ==== sim/tb_serial_link.sv ====
////////////////////
// Serial link testbench
// Clock, reset, loopback of the lanes
// Random stimulus, model queue feed, timeout
////////////////////

`include "serial_link_macros.svh"

module tb_serial_link;
  import serial_link_pkg::*;

  // Per word up to two frames at divider 8, plus idle and hold phases
  localparam int unsigned TotalWords    = 1 + 40 + `SL_NUM_CREDITS + 1 + 30;
  localparam int unsigned TimeoutCycles = TotalWords * `SL_NUM_FLITS * 2 * 8 * 2 + 2000;

  typedef enum logic [1:0] {
    READY_HIGH,
    READY_LOW,
    READY_RANDOM
  } ready_mode_e;

  logic        clk_i;
  logic        rst_i;
  clk_div_t    clk_div;
  word_t       tx_word;
  logic        tx_valid;
  logic        tx_ready;
  word_t       rx_word;
  logic        rx_valid;
  logic        rx_ready = 1'b1;
  flit_t       lanes;
  logic        fwd_clk;
  ready_mode_e ready_mode = READY_HIGH;
  integer      seed = 43321;
  integer      ready_seed = 43321;
  int unsigned cycle_cnt = 0;
  int unsigned accepted;
  logic        taken;

  serial_link uut (
    .clk_i         ( clk_i    ),
    .rst_i         ( rst_i    ),
    .clk_div_i     ( clk_div  ),
    .tx_word_i     ( tx_word  ),
    .tx_valid_i    ( tx_valid ),
    .tx_ready_o    ( tx_ready ),
    .rx_word_o     ( rx_word  ),
    .rx_valid_o    ( rx_valid ),
    .rx_ready_i    ( rx_ready ),
    .ddr_o         ( lanes    ),
    .ddr_rcv_clk_o ( fwd_clk  ),
    .ddr_i         ( lanes    ),
    .ddr_rcv_clk_i ( fwd_clk  )
  );

  serial_link_checker chk (
    .clk_i         ( clk_i    ),
    .tx_ready_i    ( tx_ready ),
    .rx_word_i     ( rx_word  ),
    .rx_valid_i    ( rx_valid ),
    .rx_ready_i    ( rx_ready ),
    .ddr_i         ( lanes    ),
    .ddr_rcv_clk_i ( fwd_clk  )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Monitors and drivers
  ////////////////////

  // Accepted words feed the model queue
  always @(posedge clk_i) begin
    if (!rst_i && tx_valid && tx_ready) begin
      chk.push_word(tx_word);
    end
  end

  always @(negedge clk_i) begin
    case (ready_mode)
      READY_LOW:    rx_ready = 1'b0;
      READY_RANDOM: rx_ready = ($random(ready_seed) & 1) != 0;
      default:      rx_ready = 1'b1;
    endcase
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Run timed out after %0d cycles with words still outstanding", TimeoutCycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic drive_word(input word_t w);
    @(negedge clk_i);
    tx_valid = 1'b1;
    tx_word  = w;
  endtask

  // Waits for the handshake on the word already driven
  task automatic wait_accept(input int unsigned max_cycles, output logic ok);
    int unsigned waited;
    waited = 0;
    ok     = 1'b0;
    while (!ok && waited < max_cycles) begin
      @(posedge clk_i);
      ok = tx_ready;
      waited++;
    end
  endtask

  task automatic wait_handshake();
    @(posedge clk_i);
    while (!tx_ready) begin
      @(posedge clk_i);
    end
  endtask

  task automatic send_word(input word_t w);
    drive_word(w);
    wait_handshake();
  endtask

  task automatic stop_tx();
    @(negedge clk_i);
    tx_valid = 1'b0;
  endtask

  task automatic drain_rx();
    while (chk.pending_count() != 0) begin
      @(posedge clk_i);
    end
    // Idle window to catch any extra word
    repeat (200) @(posedge clk_i);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    rst_i    = 1'b1;
    clk_div  = clk_div_t'(4);
    tx_word  = '0;
    tx_valid = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    chk.check_reset_state();
    chk.end_test("1 reset state");

    send_word(word_t'($random(seed)));
    stop_tx();
    drain_rx();
    chk.end_test("2 single word");

    repeat (40) send_word(word_t'($random(seed)));
    stop_tx();
    drain_rx();
    chk.end_test("3 random stream");

    ready_mode = READY_LOW;
    @(negedge clk_i);
    clk_div  = clk_div_t'(8);
    accepted = 0;
    taken    = 1'b1;
    // The last offered word stays on the bus until credits come back
    while (taken && accepted <= `SL_NUM_CREDITS) begin
      drive_word(word_t'($random(seed)));
      wait_accept(400, taken);
      if (taken) begin
        accepted++;
      end
    end
    chk.compare("accepted words", 32'(`SL_NUM_CREDITS), 32'(accepted));
    chk.end_test("4 back-pressure");

    ready_mode = READY_RANDOM;
    wait_handshake();
    repeat (30) send_word(word_t'($random(seed)));
    stop_tx();
    drain_rx();
    chk.end_test("5 credit return");

    $display("Tests run %0d, passed %0d, failed %0d",
             chk.tests_passed + chk.tests_failed, chk.tests_passed, chk.tests_failed);
    if (chk.tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/serial_link_pkg.sv
design/serial_link_flow_ctrl.sv
design/serial_link_data_link.sv
design/serial_link_phy_tx.sv
design/serial_link_phy_rx.sv
design/serial_link.sv
sim/serial_link_checker.sv
sim/tb_serial_link.sv

// ==== Bender.yml ====
package:
  name: serial_link

sources:
  - include_dirs:
      - design
    files:
      - design/serial_link_pkg.sv
      - design/serial_link_flow_ctrl.sv
      - design/serial_link_data_link.sv
      - design/serial_link_phy_tx.sv
      - design/serial_link_phy_rx.sv
      - design/serial_link.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/serial_link_checker.sv
      - sim/tb_serial_link.sv
